// ==== source/mem_pkg.sv ====
// Memory pipeline shared definitions.
// Access kinds, the request and tag layouts, and the data and register widths.
`default_nettype none

package mem_pkg;

	localparam int DATA_W = 32;	// width of a data word.
	localparam int REG_W = 5;	// width of a destination register number.

	// kind of access, loads first and then stores.
	typedef enum logic [2:0]
	{
		OP_LB = 3'd0,	// load byte, sign extended.
		OP_LBU = 3'd1,	// load byte, zero extended.
		OP_LH = 3'd2,	// load halfword, sign extended.
		OP_LHU = 3'd3,	// load halfword, zero extended.
		OP_LW = 3'd4,	// load word.
		OP_SB = 3'd5,	// store byte.
		OP_SH = 3'd6,	// store halfword.
		OP_SW = 3'd7	// store word.
	} mem_op_t;

	// A request as captured at the pipeline input, 72 bits.
	typedef struct packed
	{
		mem_op_t op;
		logic [DATA_W-1:0] addr;
		logic [DATA_W-1:0] store_value;
		logic [REG_W-1:0] dest_reg;
	} mem_req_t;

	// Sideband that rides through the RAM next to the read word, 10 bits.
	// the offset selects the byte lane for the load extraction.
	typedef struct packed
	{
		mem_op_t op;
		logic [1:0] offset;
		logic [REG_W-1:0] dest_reg;
	} mem_tag_t;

endpackage

`default_nettype wire

// ==== source/pipe_reg.sv ====
// One-entry pipeline register with valid/ready handshakes on both sides.
// The payload type is a parameter so one block serves every stage.
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
	parameter type payload_t = logic [31:0]
) (
	input logic clk,
	input logic rst_i,

	input logic in_valid_i,
	output logic in_ready_o,
	input payload_t in_data_i,

	output logic out_valid_o,
	input logic out_ready_i,
	output payload_t out_data_o
);

	logic valid_q;
	payload_t data_q;
	logic in_fire;

	// The slot can take new data when empty or when it drains this cycle.
	assign in_ready_o = !valid_q || out_ready_i;
	assign in_fire = in_valid_i && in_ready_o;

	always_ff @(posedge clk)
	begin
		if (rst_i)
			valid_q <= 1'b0;
		else if (in_ready_o)
			valid_q <= in_valid_i;	// refill or empty on a drain.
	end

	// payload only moves on a transfer, so it holds while stalled.
	always_ff @(posedge clk)
	begin
		if (in_fire)
			data_q <= in_data_i;
	end

	assign out_valid_o = valid_q;
	assign out_data_o = data_q;

endmodule

`default_nettype wire

// ==== source/memory_access_stage.sv ====
// Memory access stage, issues one load or store to the data RAM.
// Store data is steered into byte lanes and byte enables are formed here.
`timescale 1ns/1ps
`default_nettype none

module memory_access_stage #(
	parameter int DEPTH = 64
) (
	input logic req_valid_i,
	output logic req_ready_o,
	input mem_pkg::mem_req_t req_i,

	output logic ram_valid_o,
	input logic ram_ready_i,
	output logic ram_write_o,
	output logic [3:0] ram_sel_o,
	output logic [mem_pkg::DATA_W-1:0] ram_wdata_o,
	output logic [$clog2(DEPTH)-1:0] ram_index_o,
	output mem_pkg::mem_tag_t ram_tag_o
);

	import mem_pkg::*;

	logic [1:0] offset;
	logic [DATA_W-1:0] value;

	assign offset = req_i.addr[1:0];
	assign value = req_i.store_value;

	// This stage has no storage, the RAM handshake passes straight through.
	assign ram_valid_o = req_valid_i;
	assign req_ready_o = ram_ready_i;

	assign ram_write_o = req_i.op inside {OP_SB, OP_SH, OP_SW};
	assign ram_index_o = req_i.addr[2 +: $clog2(DEPTH)];	// upper bits wrap.

	// Lane k holds the byte at offset k, in bits 31-8k down, enable bit 3-k.
	always_comb
	begin
		ram_sel_o = 4'b1111;
		ram_wdata_o = {value[7:0], value[15:8], value[23:16], value[31:24]};
		case (req_i.op)
			OP_LB, OP_LBU, OP_SB:
			begin
				case (offset)
					2'd0:
					begin
						ram_sel_o = 4'b1000;
						ram_wdata_o = {value[7:0], 24'd0};
					end
					2'd1:
					begin
						ram_sel_o = 4'b0100;
						ram_wdata_o = {8'd0, value[7:0], 16'd0};
					end
					2'd2:
					begin
						ram_sel_o = 4'b0010;
						ram_wdata_o = {16'd0, value[7:0], 8'd0};
					end
					default:
					begin
						ram_sel_o = 4'b0001;
						ram_wdata_o = {24'd0, value[7:0]};
					end
				endcase
			end
			OP_LH, OP_LHU, OP_SH:
			begin
				// offset bit 0 is ignored, the low byte takes the lower address.
				if (!offset[1])
				begin
					ram_sel_o = 4'b1100;
					ram_wdata_o = {value[7:0], value[15:8], 16'd0};
				end
				else
				begin
					ram_sel_o = 4'b0011;
					ram_wdata_o = {16'd0, value[7:0], value[15:8]};
				end
			end
			default:
			begin
			end
		endcase
	end

	// The load side needs the offset to pick the lane back out.
	always_comb
	begin
		ram_tag_o.op = req_i.op;
		ram_tag_o.offset = offset;
		ram_tag_o.dest_reg = req_i.dest_reg;
	end

endmodule

`default_nettype wire

// ==== source/data_ram.sv ====
// Byte-enabled single-port data RAM, always hits in one cycle.
// The read word and its tag sit in a response register that holds under stall.
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
	parameter int DEPTH = 64,
	parameter type tag_t = logic [9:0]
) (
	input logic clk,
	input logic rst_i,

	input logic req_valid_i,
	output logic req_ready_o,
	input logic write_i,
	input logic [3:0] sel_i,
	input logic [31:0] wdata_i,
	input logic [$clog2(DEPTH)-1:0] index_i,
	input tag_t tag_i,

	output logic rsp_valid_o,
	input logic rsp_ready_i,
	output logic [31:0] rdata_o,
	output tag_t tag_o
);

	logic [31:0] mem [DEPTH];
	logic rsp_valid_q;
	logic [31:0] rdata_q;
	tag_t tag_q;
	logic req_fire;

	// Accept only when the response slot is free or being taken.
	assign req_ready_o = !rsp_valid_q || rsp_ready_i;
	assign req_fire = req_valid_i && req_ready_o;

	always_ff @(posedge clk)
	begin
		if (req_fire && write_i)
		begin
			for (int i = 0; i < 4; i++)
			begin
				if (sel_i[i])
					mem[index_i][8*i +: 8] <= wdata_i[8*i +: 8];
			end
		end
	end

	// A store reads the old word, it is dropped later but keeps one result per request.
	always_ff @(posedge clk)
	begin
		if (req_fire)
		begin
			rdata_q <= mem[index_i];
			tag_q <= tag_i;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
			rsp_valid_q <= 1'b0;
		else if (req_ready_o)
			rsp_valid_q <= req_valid_i;
	end

	assign rsp_valid_o = rsp_valid_q;
	assign rdata_o = rdata_q;
	assign tag_o = tag_q;

endmodule

`default_nettype wire

// ==== source/load_writeback_stage.sv ====
// Load writeback stage, picks the addressed byte, halfword or word and extends it.
// The result goes into an output register toward the register file.
`timescale 1ns/1ps
`default_nettype none

module load_writeback_stage (
	input logic clk,
	input logic rst_i,

	input logic rsp_valid_i,
	output logic rsp_ready_o,
	input logic [mem_pkg::DATA_W-1:0] rdata_i,
	input mem_pkg::mem_tag_t tag_i,

	output logic out_valid_o,
	input logic out_ready_i,
	output logic out_has_writeback_o,
	output logic [mem_pkg::REG_W-1:0] out_reg_o,
	output logic [mem_pkg::DATA_W-1:0] out_data_o
);

	import mem_pkg::*;

	typedef struct packed
	{
		logic has_writeback;
		logic [REG_W-1:0] dest_reg;
		logic [DATA_W-1:0] data;
	} wb_t;

	logic [7:0] byte_val;
	logic [15:0] half_val;
	logic [31:0] word_val;
	wb_t wb_in;
	wb_t wb_out;

	// Undo the lane order, offset 0 is the top byte of the read word.
	always_comb
	begin
		case (tag_i.offset)
			2'd0: byte_val = rdata_i[31:24];
			2'd1: byte_val = rdata_i[23:16];
			2'd2: byte_val = rdata_i[15:8];
			default: byte_val = rdata_i[7:0];
		endcase
		if (tag_i.offset[1])
			half_val = {rdata_i[7:0], rdata_i[15:8]};
		else
			half_val = {rdata_i[23:16], rdata_i[31:24]};
		word_val = {rdata_i[7:0], rdata_i[15:8], rdata_i[23:16], rdata_i[31:24]};
	end

	always_comb
	begin
		wb_in.has_writeback = 1'b1;
		wb_in.dest_reg = tag_i.dest_reg;
		case (tag_i.op)
			OP_LB: wb_in.data = {{24{byte_val[7]}}, byte_val};
			OP_LBU: wb_in.data = {24'd0, byte_val};
			OP_LH: wb_in.data = {{16{half_val[15]}}, half_val};
			OP_LHU: wb_in.data = {16'd0, half_val};
			OP_LW: wb_in.data = word_val;
			default:
			begin
				wb_in.has_writeback = 1'b0;	// stores only retire.
				wb_in.data = '0;
			end
		endcase
	end

	pipe_reg #(
		.payload_t(wb_t)
	) u_out_reg (
		.clk(clk),
		.rst_i(rst_i),
		.in_valid_i(rsp_valid_i),
		.in_ready_o(rsp_ready_o),
		.in_data_i(wb_in),
		.out_valid_o(out_valid_o),
		.out_ready_i(out_ready_i),
		.out_data_o(wb_out)
	);

	assign out_has_writeback_o = wb_out.has_writeback;
	assign out_reg_o = wb_out.dest_reg;
	assign out_data_o = wb_out.data;

endmodule

`default_nettype wire

// ==== source/mem_pipeline_top.sv ====
// Memory pipeline top, input register, access stage, data RAM and writeback.
// Three register stages, one request per cycle, results in issue order.
`timescale 1ns/1ps
`default_nettype none

module mem_pipeline_top #(
	parameter int DEPTH = 64
) (
	input logic clk,
	input logic rst_i,

	input logic in_valid_i,
	output logic in_ready_o,
	input mem_pkg::mem_op_t in_op_i,
	input logic [mem_pkg::DATA_W-1:0] in_addr_i,
	input logic [mem_pkg::DATA_W-1:0] in_store_value_i,
	input logic [mem_pkg::REG_W-1:0] in_reg_i,

	output logic out_valid_o,
	input logic out_ready_i,
	output logic out_has_writeback_o,
	output logic [mem_pkg::REG_W-1:0] out_reg_o,
	output logic [mem_pkg::DATA_W-1:0] out_data_o
);

	import mem_pkg::*;

	localparam int IDX_W = $clog2(DEPTH);

	mem_req_t in_req;
	mem_req_t req;
	logic req_valid;
	logic req_ready;

	logic ram_valid;
	logic ram_ready;
	logic ram_write;
	logic [3:0] ram_sel;
	logic [DATA_W-1:0] ram_wdata;
	logic [IDX_W-1:0] ram_index;
	mem_tag_t ram_tag;

	logic rsp_valid;
	logic rsp_ready;
	logic [DATA_W-1:0] rsp_rdata;
	mem_tag_t rsp_tag;

	assign in_req = '{op: in_op_i, addr: in_addr_i, store_value: in_store_value_i,
		dest_reg: in_reg_i};

	pipe_reg #(.payload_t(mem_req_t)) u_in_reg (
		.clk(clk), .rst_i(rst_i),
		.in_valid_i(in_valid_i), .in_ready_o(in_ready_o), .in_data_i(in_req),
		.out_valid_o(req_valid), .out_ready_i(req_ready), .out_data_o(req)
	);

	memory_access_stage #(.DEPTH(DEPTH)) u_memory_access_stage (
		.req_valid_i(req_valid), .req_ready_o(req_ready), .req_i(req),
		.ram_valid_o(ram_valid), .ram_ready_i(ram_ready), .ram_write_o(ram_write),
		.ram_sel_o(ram_sel), .ram_wdata_o(ram_wdata), .ram_index_o(ram_index),
		.ram_tag_o(ram_tag)
	);

	data_ram #(.DEPTH(DEPTH), .tag_t(mem_tag_t)) u_data_ram (
		.clk(clk), .rst_i(rst_i),
		.req_valid_i(ram_valid), .req_ready_o(ram_ready), .write_i(ram_write),
		.sel_i(ram_sel), .wdata_i(ram_wdata), .index_i(ram_index), .tag_i(ram_tag),
		.rsp_valid_o(rsp_valid), .rsp_ready_i(rsp_ready), .rdata_o(rsp_rdata),
		.tag_o(rsp_tag)
	);

	load_writeback_stage u_load_writeback_stage (
		.clk(clk), .rst_i(rst_i),
		.rsp_valid_i(rsp_valid), .rsp_ready_o(rsp_ready), .rdata_i(rsp_rdata),
		.tag_i(rsp_tag),
		.out_valid_o(out_valid_o), .out_ready_i(out_ready_i),
		.out_has_writeback_o(out_has_writeback_o), .out_reg_o(out_reg_o),
		.out_data_o(out_data_o)
	);

endmodule

`default_nettype wire

// ==== tests/mem_pipeline_tb.sv ====
// Testbench for the memory pipeline top level.
// Table-driven loads and stores checked against a byte-array memory model.
`timescale 1ns/1ps
`default_nettype none

module mem_pipeline_tb;

	import mem_pkg::*;

	localparam int DEPTH = 64;
	localparam int BYTES = DEPTH * 4;	// address space seen by the RAM, wraps above.
	localparam time PERIOD = 100;

	typedef struct {
		mem_op_t op;
		logic [31:0] addr;
		logic [31:0] value;
		logic [4:0] dest;
	} entry_t;

	typedef struct {
		logic has_wb;
		logic [4:0] dest;
		logic [31:0] data;
	} result_t;

	logic clk;
	logic rst_i;
	logic in_valid_i;
	logic in_ready_o;
	mem_op_t in_op_i;
	logic [31:0] in_addr_i;
	logic [31:0] in_store_value_i;
	logic [4:0] in_reg_i;
	logic out_valid_o;
	logic out_ready_i;
	logic out_has_writeback_o;
	logic [4:0] out_reg_o;
	logic [31:0] out_data_o;

	entry_t table_q[$];
	result_t exp_q[$];
	logic [7:0] model_mem [BYTES];
	logic [31:0] rng_state = 32'h4fff;
	logic table_ready = 1'b0;
	logic bp_phase = 1'b0;	// random out_ready_i once set.
	int n_directed;
	int n_results = 0;

	mem_pipeline_top #(.DEPTH(DEPTH)) u_mem_pipeline_top (
		.clk(clk), .rst_i(rst_i),
		.in_valid_i(in_valid_i), .in_ready_o(in_ready_o), .in_op_i(in_op_i),
		.in_addr_i(in_addr_i), .in_store_value_i(in_store_value_i), .in_reg_i(in_reg_i),
		.out_valid_o(out_valid_o), .out_ready_i(out_ready_i),
		.out_has_writeback_o(out_has_writeback_o), .out_reg_o(out_reg_o),
		.out_data_o(out_data_o)
	);

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Done: errors found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_data(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		if (got !== exp)
			abort_run($sformatf("Mismatch at %0d ns: %s got %h expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_reg(input logic [4:0] got, input logic [4:0] exp,
		input string what);
		if (got !== exp)
			abort_run($sformatf("Mismatch at %0d ns: %s got %0d expected %0d",
				$time, what, got, exp));
	endtask

	task automatic check_writeback(input logic got, input logic exp, input string what);
		if (got !== exp)
			abort_run($sformatf("Mismatch at %0d ns: %s got %b expected %b",
				$time, what, got, exp));
	endtask

	task automatic add_entry(input mem_op_t op, input logic [31:0] addr, input logic [31:0] value,
		input logic [4:0] dest);
		entry_t e;
		e.op = op;
		e.addr = addr;
		e.value = value;
		e.dest = dest;
		table_q.push_back(e);
	endtask

	// byte at offset k of a value sits at address base+k, least significant first.
	function automatic result_t expected_result(input entry_t e);
		result_t r;
		int b;
		int h;
		int w;
		b = int'(e.addr % BYTES);
		h = b & ~1;	// halfwords ignore address bit 0.
		w = b & ~3;
		r.has_wb = 1'b1;
		r.dest = e.dest;
		case (e.op)
			OP_LB: r.data = {{24{model_mem[b][7]}}, model_mem[b]};
			OP_LBU: r.data = {24'd0, model_mem[b]};
			OP_LH: r.data = {{16{model_mem[h + 1][7]}}, model_mem[h + 1], model_mem[h]};
			OP_LHU: r.data = {16'd0, model_mem[h + 1], model_mem[h]};
			OP_LW: r.data = {model_mem[w + 3], model_mem[w + 2], model_mem[w + 1], model_mem[w]};
			default:
			begin
				r.has_wb = 1'b0;
				r.data = 32'd0;
			end
		endcase
		return r;
	endfunction

	task automatic update_model(input entry_t e);
		int b;
		b = int'(e.addr % BYTES);
		case (e.op)
			OP_SB: model_mem[b] = e.value[7:0];
			OP_SH:
			begin
				model_mem[b & ~1] = e.value[7:0];
				model_mem[(b & ~1) + 1] = e.value[15:8];
			end
			OP_SW:
			begin
				for (int k = 0; k < 4; k++)
					model_mem[(b & ~3) + k] = e.value[8*k +: 8];
			end
			default:
			begin
			end
		endcase
	endtask

	// out_ready_i is held high until the back-pressure part of the table starts.
	always @(posedge clk)
	begin
		#1;
		if (bp_phase)
			out_ready_i = next_random() >> 7 & 1;
		else
			out_ready_i = 1'b1;
	end

	// inputs only move just after a rising edge, so the falling edge sees settled values.
	always @(negedge clk)
	begin
		result_t e;
		if (!rst_i && out_valid_o && out_ready_i)
		begin
			if (exp_q.size() == 0)
				abort_run("The pipeline produced a result that no request asked for.");
			e = exp_q.pop_front();
			check_writeback(out_has_writeback_o, e.has_wb,
				$sformatf("result %0d writeback", n_results));
			if (e.has_wb)
				check_reg(out_reg_o, e.dest, $sformatf("result %0d register", n_results));
			check_data(out_data_o, e.data, $sformatf("result %0d data", n_results));
			n_results++;
		end
	end

	initial
	begin
		wait (table_ready);
		repeat (table_q.size() * 20) @(posedge clk);
		abort_run($sformatf("Timeout: the pipeline stopped producing results after %0d of %0d.",
			n_results, table_q.size()));
	end

	initial
	begin
		logic [31:0] r;
		logic accepted;
		rst_i = 1'b1;
		in_valid_i = 1'b0;
		in_op_i = OP_LW;
		in_addr_i = 32'd0;
		in_store_value_i = 32'd0;
		in_reg_i = 5'd0;
		out_ready_i = 1'b1;

		// word round trip, with 0x100 and 0x204 wrapping onto words 0 and 1.
		add_entry(OP_SW, 32'h000, 32'h1122_3344, 5'd1);
		add_entry(OP_SW, 32'h004, 32'ha5a5_0f0f, 5'd2);
		add_entry(OP_SW, 32'h0fc, 32'hdead_beef, 5'd3);
		add_entry(OP_LW, 32'h000, 32'h0, 5'd4);
		add_entry(OP_LW, 32'h004, 32'h0, 5'd5);
		add_entry(OP_LW, 32'h0fc, 32'h0, 5'd6);
		add_entry(OP_LW, 32'h100, 32'h0, 5'd7);
		add_entry(OP_SW, 32'h204, 32'hcafe_f00d, 5'd8);
		add_entry(OP_LW, 32'h004, 32'h0, 5'd9);
		// byte order, upper value bits must not leak into other lanes.
		add_entry(OP_SB, 32'h010, 32'hffff_ff11, 5'd10);
		add_entry(OP_SB, 32'h011, 32'heeee_ee22, 5'd11);
		add_entry(OP_SB, 32'h012, 32'hdddd_dd33, 5'd12);
		add_entry(OP_SB, 32'h013, 32'hcccc_cc44, 5'd13);
		add_entry(OP_LW, 32'h010, 32'h0, 5'd14);
		add_entry(OP_SH, 32'h020, 32'hbbbb_5566, 5'd15);
		add_entry(OP_SH, 32'h022, 32'haaaa_7788, 5'd16);
		add_entry(OP_LW, 32'h020, 32'h0, 5'd17);
		add_entry(OP_SH, 32'h023, 32'h0000_99aa, 5'd18);
		add_entry(OP_LW, 32'h020, 32'h0, 5'd19);
		// sign and zero extension from each offset.
		add_entry(OP_SW, 32'h040, 32'h80ff_7f81, 5'd20);
		add_entry(OP_LB, 32'h040, 32'h0, 5'd21);
		add_entry(OP_LBU, 32'h040, 32'h0, 5'd22);
		add_entry(OP_LB, 32'h041, 32'h0, 5'd23);
		add_entry(OP_LB, 32'h042, 32'h0, 5'd24);
		add_entry(OP_LBU, 32'h043, 32'h0, 5'd25);
		add_entry(OP_LB, 32'h043, 32'h0, 5'd26);
		add_entry(OP_LH, 32'h040, 32'h0, 5'd27);
		add_entry(OP_LH, 32'h042, 32'h0, 5'd28);
		add_entry(OP_LHU, 32'h042, 32'h0, 5'd29);
		add_entry(OP_LHU, 32'h041, 32'h0, 5'd30);
		n_directed = table_q.size();
		// back-pressure part, the region is filled first so every load reads known data.
		for (int i = 0; i < 8; i++)
			add_entry(OP_SW, 32'h080 + 4 * i, next_random(), 5'(i));
		for (int i = 0; i < 32; i++)
		begin
			r = next_random();
			add_entry(mem_op_t'(r[2:0]), 32'h080 + {27'd0, r[8:4]}, next_random(), r[20:16]);
		end
		table_ready = 1'b1;

		@(posedge clk);
		repeat (2)
		begin
			@(negedge clk);
			check_writeback(out_valid_o, 1'b0, "out_valid_o in reset");
			check_writeback(in_ready_o, 1'b1, "in_ready_o in reset");
			@(posedge clk);
		end
		#1 rst_i = 1'b0;
		@(negedge clk);
		check_writeback(out_valid_o, 1'b0, "out_valid_o after reset");
		check_writeback(in_ready_o, 1'b1, "in_ready_o after reset");
		@(posedge clk);
		#1;

		for (int i = 0; i < table_q.size(); i++)
		begin
			bp_phase = (i >= n_directed);
			in_valid_i = 1'b1;
			in_op_i = table_q[i].op;
			in_addr_i = table_q[i].addr;
			in_store_value_i = table_q[i].value;
			in_reg_i = table_q[i].dest;
			do
			begin
				@(negedge clk);
				accepted = in_ready_o;
				if (accepted)
				begin
					exp_q.push_back(expected_result(table_q[i]));
					update_model(table_q[i]);
				end
				@(posedge clk);
				#1;
			end
			while (!accepted);
		end
		in_valid_i = 1'b0;

		wait (n_results == table_q.size());
		repeat (5) @(posedge clk);	// a duplicate result would show up here.
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
source/mem_pkg.sv
source/pipe_reg.sv
source/memory_access_stage.sv
source/data_ram.sv
source/load_writeback_stage.sv
source/mem_pipeline_top.sv
tests/mem_pipeline_tb.sv

// ==== Bender.yml ====
package:
  name: mem_pipeline

sources:
  - files:
      - source/mem_pkg.sv
      - source/pipe_reg.sv
      - source/memory_access_stage.sv
      - source/data_ram.sv
      - source/load_writeback_stage.sv
      - source/mem_pipeline_top.sv
  - target: test
    files:
      - tests/mem_pipeline_tb.sv
